// File: hdl/cache_geom_pkg.sv
// cache geometry and the request address layout
// the address union gives two views of one 32-bit byte address

package cache_geom_pkg;

    // line and address widths
    localparam int line_bits      = 512;
    localparam int line_addr_bits = 26;
    localparam int tag_bits       = 20;
    localparam int index_bits     = 6;
    localparam int offset_bits    = 6;

    // store sizes
    localparam int sets            = 64;
    localparam int victim_entries  = 4;
    localparam int victim_ptr_bits = 2;

    // direct-mapped view for the first-level store
    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [index_bits-1:0]  index;
        logic [offset_bits-1:0] offset;
    } addr_tio_s;

    // whole-line view for the victim buffer and memory port
    typedef struct packed {
        logic [line_addr_bits-1:0] line;
        logic [offset_bits-1:0]    offset;
    } addr_lo_s;

    typedef union packed {
        addr_tio_s tio;
        addr_lo_s  la;
    } cache_addr_u;

endpackage

// File: hdl/cache_link_pkg.sv
// credit budgets and response codes for the client and memory links

package cache_link_pkg;

    // client side credits which also set the request queue depth
    localparam int client_credits     = 2;
    localparam int client_credit_bits = $clog2(client_credits + 1);
    localparam int queue_ptr_bits     = $clog2(client_credits);

    // memory side
    localparam int mem_credits     = 2;
    localparam int mem_credit_bits = $clog2(mem_credits + 1);

    // which store answered a read
    typedef enum logic [1:0] {
        src_l1     = 2'd0,
        src_victim = 2'd1,
        src_mem    = 2'd2
    } rsp_src_e;

endpackage

// File: hdl/line_store.sv
`timescale 1ns/100ps
// direct-mapped first-level store of 64 lines with tag, valid and data
// lookup is registered one cycle; a fill writes the indexed line

module line_store (
    input  logic                                   clk,
    input  logic                                   rstn,
    input  logic [cache_geom_pkg::index_bits-1:0]  index,
    input  logic [cache_geom_pkg::tag_bits-1:0]    tag,
    input  logic                                   fill,
    input  logic [cache_geom_pkg::line_bits-1:0]   fill_data,
    output logic                                   hit,
    output logic                                   valid,
    output logic [cache_geom_pkg::tag_bits-1:0]    old_tag,
    output logic [cache_geom_pkg::line_bits-1:0]   data
);

    logic [cache_geom_pkg::sets-1:0]      valid_arr;
    logic [cache_geom_pkg::tag_bits-1:0]  tag_arr [cache_geom_pkg::sets];
    logic [cache_geom_pkg::line_bits-1:0] data_arr [cache_geom_pkg::sets];
    // tag that was looked up, compared against the resident one
    logic [cache_geom_pkg::tag_bits-1:0]  look_tag;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_arr <= '0;
        end else if (fill) begin
            valid_arr[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_arr[index]  <= tag;
            data_arr[index] <= fill_data;
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= 1'b0;
        end else begin
            valid <= valid_arr[index];
        end
    end

    always_ff @(posedge clk) begin
        old_tag  <= tag_arr[index];
        data     <= data_arr[index];
        look_tag <= tag;
    end

    assign hit = valid && (old_tag == look_tag);

endmodule

// File: hdl/victim_buffer.sv
`timescale 1ns/100ps
// four-entry fully associative victim store for lines pushed out of L1
// combinational lookup, round-robin insert, invalidate by line address

module victim_buffer (
    input  logic                                      clk,
    input  logic                                      rstn,
    input  logic [cache_geom_pkg::line_addr_bits-1:0] line,
    input  logic                                      insert,
    input  logic [cache_geom_pkg::line_addr_bits-1:0] insert_line,
    input  logic [cache_geom_pkg::line_bits-1:0]      insert_data,
    input  logic                                      invalidate,
    output logic                                      hit,
    output logic [cache_geom_pkg::line_bits-1:0]      data
);

    logic [cache_geom_pkg::victim_entries-1:0]  ent_valid;
    logic [cache_geom_pkg::line_addr_bits-1:0]  ent_line [cache_geom_pkg::victim_entries];
    logic [cache_geom_pkg::line_bits-1:0]       ent_data [cache_geom_pkg::victim_entries];
    logic [cache_geom_pkg::victim_ptr_bits-1:0] ins_ptr;
    logic [cache_geom_pkg::victim_entries-1:0]  match;
    logic [cache_geom_pkg::victim_ptr_bits-1:0] hit_sel;

    always_comb begin
        for (int i = 0; i < cache_geom_pkg::victim_entries; i++) begin
            match[i] = ent_valid[i] && (ent_line[i] == line);
        end
    end

    // lowest-numbered matching entry wins
    always_comb begin
        hit_sel = '0;
        for (int i = cache_geom_pkg::victim_entries - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_sel = i[cache_geom_pkg::victim_ptr_bits-1:0];
            end
        end
    end

    assign hit  = |match;
    assign data = hit ? ent_data[hit_sel] : '0;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ent_valid <= '0;
            ins_ptr   <= '0;
        end else begin
            for (int i = 0; i < cache_geom_pkg::victim_entries; i++) begin
                // insert takes priority over invalidate at its own slot
                if (insert && (ins_ptr == i[cache_geom_pkg::victim_ptr_bits-1:0])) begin
                    ent_valid[i] <= 1'b1;
                end else if (invalidate && match[i]) begin
                    ent_valid[i] <= 1'b0;
                end
            end
            if (insert) begin
                ins_ptr <= ins_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (insert) begin
            ent_line[ins_ptr] <= insert_line;
            ent_data[ins_ptr] <= insert_data;
        end
    end

endmodule

// File: hdl/cache_ctrl.sv
`timescale 1ns/100ps
// cache controller with the request queue, credit counters and lookup FSM
// drives the L1 store and victim buffer, and sequences the memory port

module cache_ctrl (
    input  logic                                      clk,
    input  logic                                      rstn,
    input  logic                                      req_valid,
    input  logic                                      req_write,
    input  cache_geom_pkg::cache_addr_u               req_addr,
    input  logic [cache_geom_pkg::line_bits-1:0]      req_data,
    output logic                                      req_credit,
    output logic                                      rsp_valid,
    output logic [cache_geom_pkg::line_bits-1:0]      rsp_data,
    output cache_link_pkg::rsp_src_e                  rsp_src,
    output logic                                      mem_req_valid,
    output logic                                      mem_req_write,
    output logic [cache_geom_pkg::line_addr_bits-1:0] mem_req_line,
    output logic [cache_geom_pkg::line_bits-1:0]      mem_req_data,
    input  logic                                      mem_credit,
    input  logic                                      mem_rsp_valid,
    input  logic [cache_geom_pkg::line_bits-1:0]      mem_rsp_data,
    output logic [cache_geom_pkg::index_bits-1:0]     ls_index,
    output logic [cache_geom_pkg::tag_bits-1:0]       ls_tag,
    output logic                                      ls_fill,
    output logic [cache_geom_pkg::line_bits-1:0]      ls_fill_data,
    input  logic                                      ls_hit,
    input  logic                                      ls_valid,
    input  logic [cache_geom_pkg::tag_bits-1:0]       ls_old_tag,
    input  logic [cache_geom_pkg::line_bits-1:0]      ls_data,
    output logic [cache_geom_pkg::line_addr_bits-1:0] vb_line,
    output logic                                      vb_insert,
    output logic [cache_geom_pkg::line_addr_bits-1:0] vb_insert_line,
    output logic [cache_geom_pkg::line_bits-1:0]      vb_insert_data,
    output logic                                      vb_invalidate,
    input  logic                                      vb_hit,
    input  logic [cache_geom_pkg::line_bits-1:0]      vb_data
);

    typedef enum logic [2:0] {
        st_idle, st_lookup, st_swap, st_fetch, st_wait
    } state_e;

    // request queue sized to the client credit budget
    logic                                       q_write [cache_link_pkg::client_credits];
    cache_geom_pkg::cache_addr_u                q_addr [cache_link_pkg::client_credits];
    logic [cache_geom_pkg::line_bits-1:0]       q_data [cache_link_pkg::client_credits];
    logic [cache_link_pkg::queue_ptr_bits-1:0]  wr_ptr;
    logic [cache_link_pkg::queue_ptr_bits-1:0]  rd_ptr;
    logic [cache_link_pkg::client_credit_bits-1:0] q_count;
    logic [cache_link_pkg::mem_credit_bits-1:0] mem_cred;
    state_e                                     state;

    logic                                 head_write;
    cache_geom_pkg::cache_addr_u          head_addr;
    logic [cache_geom_pkg::line_bits-1:0] head_data;
    logic                                 mem_ok;
    logic                                 wr_go;
    logic                                 rd_issue;
    logic                                 fill_done;
    logic                                 pop;

    assign head_write = q_write[rd_ptr];
    assign head_addr  = q_addr[rd_ptr];
    assign head_data  = q_data[rd_ptr];
    assign mem_ok     = (mem_cred != '0);

    // write retires once its write-through can go out
    assign wr_go     = (state == st_lookup) && head_write && mem_ok;
    assign rd_issue  = (state == st_fetch) && mem_ok;
    assign fill_done = (state == st_wait) && mem_rsp_valid;
    assign pop = wr_go || fill_done || (state == st_swap) ||
                 ((state == st_lookup) && !head_write && ls_hit);

    always_ff @(posedge clk) begin
        if (req_valid) begin
            q_write[wr_ptr] <= req_write;
            q_addr[wr_ptr]  <= req_addr;
            q_data[wr_ptr]  <= req_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            q_count  <= '0;
            mem_cred <= cache_link_pkg::mem_credits[cache_link_pkg::mem_credit_bits-1:0];
        end else begin
            if (req_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({req_valid, pop})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
            case ({mem_credit, mem_req_valid})
                2'b10:   mem_cred <= mem_cred + 1'b1;
                2'b01:   mem_cred <= mem_cred - 1'b1;
                default: mem_cred <= mem_cred;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (q_count != '0) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    if (head_write) begin
                        if (mem_ok) begin
                            state <= st_idle;
                        end
                    end else if (ls_hit) begin
                        state <= st_idle;
                    end else if (vb_hit) begin
                        state <= st_swap;
                    end else begin
                        state <= st_fetch;
                    end
                end
                st_swap:  state <= st_idle;
                st_fetch: begin
                    if (mem_ok) begin
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    if (mem_rsp_valid) begin
                        state <= st_idle;
                    end
                end
                default:  state <= st_idle;
            endcase
        end
    end

    // client response one cycle after retirement
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rsp_valid  <= 1'b0;
            req_credit <= 1'b0;
        end else begin
            rsp_valid  <= pop && !head_write;
            req_credit <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_swap) begin
            rsp_data <= vb_data;
            rsp_src  <= cache_link_pkg::src_victim;
        end else if (fill_done) begin
            rsp_data <= mem_rsp_data;
            rsp_src  <= cache_link_pkg::src_mem;
        end else begin
            rsp_data <= ls_data;
            rsp_src  <= cache_link_pkg::src_l1;
        end
    end

    // memory requests only go out with a credit in hand
    assign mem_req_valid = wr_go || rd_issue;
    assign mem_req_write = head_write;
    assign mem_req_line  = head_addr.la.line;
    assign mem_req_data  = head_data;

    // L1 lookup and install
    assign ls_index = head_addr.tio.index;
    assign ls_tag   = head_addr.tio.tag;
    assign ls_fill  = wr_go || (state == st_swap) || fill_done;

    always_comb begin
        if (state == st_swap) begin
            ls_fill_data = vb_data;
        end else if (fill_done) begin
            ls_fill_data = mem_rsp_data;
        end else begin
            ls_fill_data = head_data;
        end
    end

    // a valid line with another tag is displaced into the victim buffer
    assign vb_line        = head_addr.la.line;
    assign vb_insert      = ls_fill && ls_valid && !ls_hit;
    assign vb_insert_line = {ls_old_tag, ls_index};
    assign vb_insert_data = ls_data;
    // swap removes the hit entry and a write drops any stale copy
    assign vb_invalidate  = wr_go || (state == st_swap);

endmodule

// File: hdl/dcache_top.sv
`timescale 1ns/100ps
// data cache front end wiring the controller to the L1 store and victim buffer

module dcache_top (
    input  logic                                      clk,
    input  logic                                      rstn,
    input  logic                                      req_valid,
    input  logic                                      req_write,
    input  cache_geom_pkg::cache_addr_u               req_addr,
    input  logic [cache_geom_pkg::line_bits-1:0]      req_data,
    output logic                                      req_credit,
    output logic                                      rsp_valid,
    output logic [cache_geom_pkg::line_bits-1:0]      rsp_data,
    output cache_link_pkg::rsp_src_e                  rsp_src,
    output logic                                      mem_req_valid,
    output logic                                      mem_req_write,
    output logic [cache_geom_pkg::line_addr_bits-1:0] mem_req_line,
    output logic [cache_geom_pkg::line_bits-1:0]      mem_req_data,
    input  logic                                      mem_credit,
    input  logic                                      mem_rsp_valid,
    input  logic [cache_geom_pkg::line_bits-1:0]      mem_rsp_data
);

    logic [cache_geom_pkg::index_bits-1:0]     ls_index;
    logic [cache_geom_pkg::tag_bits-1:0]       ls_tag;
    logic                                      ls_fill;
    logic [cache_geom_pkg::line_bits-1:0]      ls_fill_data;
    logic                                      ls_hit;
    logic                                      ls_valid;
    logic [cache_geom_pkg::tag_bits-1:0]       ls_old_tag;
    logic [cache_geom_pkg::line_bits-1:0]      ls_data;
    logic [cache_geom_pkg::line_addr_bits-1:0] vb_line;
    logic                                      vb_insert;
    logic [cache_geom_pkg::line_addr_bits-1:0] vb_insert_line;
    logic [cache_geom_pkg::line_bits-1:0]      vb_insert_data;
    logic                                      vb_invalidate;
    logic                                      vb_hit;
    logic [cache_geom_pkg::line_bits-1:0]      vb_data;

    cache_ctrl u_ctrl (
        .clk, .rstn,
        .req_valid, .req_write, .req_addr, .req_data,
        .req_credit, .rsp_valid, .rsp_data, .rsp_src,
        .mem_req_valid, .mem_req_write, .mem_req_line, .mem_req_data,
        .mem_credit, .mem_rsp_valid, .mem_rsp_data,
        .ls_index, .ls_tag, .ls_fill, .ls_fill_data,
        .ls_hit, .ls_valid, .ls_old_tag, .ls_data,
        .vb_line, .vb_insert, .vb_insert_line, .vb_insert_data, .vb_invalidate,
        .vb_hit, .vb_data
    );

    line_store u_l1 (
        .clk       (clk),
        .rstn      (rstn),
        .index     (ls_index),
        .tag       (ls_tag),
        .fill      (ls_fill),
        .fill_data (ls_fill_data),
        .hit       (ls_hit),
        .valid     (ls_valid),
        .old_tag   (ls_old_tag),
        .data      (ls_data)
    );

    victim_buffer u_victim (
        .clk         (clk),
        .rstn        (rstn),
        .line        (vb_line),
        .insert      (vb_insert),
        .insert_line (vb_insert_line),
        .insert_data (vb_insert_data),
        .invalidate  (vb_invalidate),
        .hit         (vb_hit),
        .data        (vb_data)
    );

endmodule

// File: dv/dcache_asserts.sv
`timescale 1ns/100ps
// credit and reset protocol checks on the cache top level
// attached to dcache_top with a bind from the testbench

module dcache_asserts (
    input logic clk,
    input logic rstn,
    input logic req_valid,
    input logic req_credit,
    input logic rsp_valid,
    input logic mem_req_valid,
    input logic mem_credit
);

    // memory credits the cache still holds
    int mem_held;
    // client requests sent and not yet credited back
    int outstanding;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mem_held    <= cache_link_pkg::mem_credits;
            outstanding <= 0;
        end else begin
            mem_held    <= mem_held + int'(mem_credit) - int'(mem_req_valid);
            outstanding <= outstanding + int'(req_valid) - int'(req_credit);
        end
    end

    a_mem_credit: assert property (@(posedge clk) disable iff (!rstn)
        mem_req_valid |-> (mem_held > 0))
        else $error("memory request issued while holding no memory credit");

    a_rsp_in_reset: assert property (@(posedge clk)
        !rstn |=> !rsp_valid)
        else $error("read response asserted during reset");

    // a credit returned for no request drives the count below zero
    a_outstanding: assert property (@(posedge clk) disable iff (!rstn)
        (outstanding >= 0) && (outstanding <= cache_link_pkg::client_credits))
        else $error("client requests outstanding fall outside the credit budget");

endmodule

// File: dv/dcache_tb.sv
`timescale 1ns/100ps
// testbench for the data cache front end with random reads and writes over
// lines that collide on a few indexes, checked against a reference model

module dcache_tb;

    localparam int num_reqs    = 400;
    localparam int num_lines   = 24;
    localparam int cycle_limit = num_reqs * 20;
    localparam int line_w      = cache_geom_pkg::line_bits;
    localparam int laddr_w     = cache_geom_pkg::line_addr_bits;
    localparam int idx_w       = cache_geom_pkg::index_bits;
    localparam int tag_w       = cache_geom_pkg::tag_bits;
    localparam int vb_n        = cache_geom_pkg::victim_entries;

    logic                          clk;
    logic                          rstn;
    logic                          req_valid;
    logic                          req_write;
    cache_geom_pkg::cache_addr_u   req_addr;
    logic [line_w-1:0]             req_data;
    logic                          req_credit;
    logic                          rsp_valid;
    logic [line_w-1:0]             rsp_data;
    cache_link_pkg::rsp_src_e      rsp_src;
    logic                          mem_req_valid;
    logic                          mem_req_write;
    logic [laddr_w-1:0]            mem_req_line;
    logic [line_w-1:0]             mem_req_data;
    logic                          mem_credit;
    logic                          mem_rsp_valid;
    logic [line_w-1:0]             mem_rsp_data;

    int seed = 32'h5213bc01;
    int cycle = 0;
    int errors = 0;
    int checks = 0;
    int credits_held;
    int credits_back = 0;
    int mem_writes = 0;
    int n_reads = 0;
    int n_writes = 0;
    int n_victim = 0;

    // stimulus built up front in issue order
    logic                 stim_write [num_reqs];
    logic [laddr_w-1:0]   stim_line [num_reqs];
    logic [line_w-1:0]    stim_data [num_reqs];

    // expected results in the order the DUT produces them
    logic [line_w-1:0]              exp_rsp_data [$];
    cache_link_pkg::rsp_src_e       exp_rsp_src [$];
    logic [laddr_w-1:0]             exp_wr_line [$];
    logic [line_w-1:0]              exp_wr_data [$];

    // reference model of a flat memory plus a shadow of L1 and victim state
    logic [line_w-1:0]    ref_mem [logic [laddr_w-1:0]];
    logic [cache_geom_pkg::sets-1:0] sh_valid = '0;
    logic [tag_w-1:0]     sh_tag [cache_geom_pkg::sets];
    logic [vb_n-1:0]      vb_valid = '0;
    logic [laddr_w-1:0]   vb_lines [vb_n];
    logic [cache_geom_pkg::victim_ptr_bits-1:0] vb_ptr = '0;

    // memory responder state
    logic [line_w-1:0]    mem_store [logic [laddr_w-1:0]];
    logic [laddr_w-1:0]   rd_line_q [$];
    int                   rd_due_q [$];
    int                   credit_due_q [$];

    dcache_top UUT (.*);

    bind dcache_top dcache_asserts u_asserts (
        .clk           (clk),
        .rstn          (rstn),
        .req_valid     (req_valid),
        .req_credit    (req_credit),
        .rsp_valid     (rsp_valid),
        .mem_req_valid (mem_req_valid),
        .mem_credit    (mem_credit)
    );

    always #10 clk = ~clk;

    // four tags on each of six indexes
    function automatic logic [laddr_w-1:0] pool_line(input int k);
        logic [idx_w-1:0] idx;
        logic [tag_w-1:0] tag;
        idx = idx_w'(7 + 9 * (k % 6));
        tag = 20'h3a5c1 + tag_w'(k / 6) * 20'h0e27;
        return {tag, idx};
    endfunction

    // contents of a line that was never written
    function automatic logic [line_w-1:0] init_pattern(input logic [laddr_w-1:0] line);
        logic [line_w-1:0] p;
        for (int w = 0; w < line_w / 32; w++) begin
            p[w*32 +: 32] = {line, 6'(w)} ^ 32'h9e37_79b9;
        end
        return p;
    endfunction

    function automatic logic [line_w-1:0] ref_read(input logic [laddr_w-1:0] line);
        if (ref_mem.exists(line)) begin
            return ref_mem[line];
        end
        return init_pattern(line);
    endfunction

    // apply one access to the shadow state and report where a read is served
    task automatic model_access(input logic is_write, input logic [laddr_w-1:0] line,
                                output cache_link_pkg::rsp_src_e src,
                                output logic [laddr_w-1:0] displaced,
                                output logic displaced_ok);
        logic [idx_w-1:0] idx;
        logic             l1_hit;
        logic             in_victim;
        idx = line[idx_w-1:0];
        l1_hit = sh_valid[idx] && (sh_tag[idx] == line[laddr_w-1:idx_w]);
        in_victim = 1'b0;
        for (int e = 0; e < vb_n; e++) begin
            if (vb_valid[e] && (vb_lines[e] == line)) begin
                in_victim = 1'b1;
            end
        end
        displaced = {sh_tag[idx], idx};
        displaced_ok = sh_valid[idx] && !l1_hit;
        if (l1_hit) begin
            src = cache_link_pkg::src_l1;
        end else if (in_victim) begin
            src = cache_link_pkg::src_victim;
        end else begin
            src = cache_link_pkg::src_mem;
        end
        if (is_write || !l1_hit) begin
            for (int e = 0; e < vb_n; e++) begin
                if (vb_lines[e] == line) begin
                    vb_valid[e] = 1'b0;
                end
            end
            if (displaced_ok) begin
                vb_lines[vb_ptr] = displaced;
                vb_valid[vb_ptr] = 1'b1;
                vb_ptr++;
            end
            sh_valid[idx] = 1'b1;
            sh_tag[idx] = line[laddr_w-1:idx_w];
        end
    endtask

    task automatic build_stimulus();
        logic [laddr_w-1:0]       follow [$];
        logic [laddr_w-1:0]       disp;
        logic                     disp_ok;
        logic                     random_pick;
        cache_link_pkg::rsp_src_e src;
        for (int k = 0; k < num_reqs; k++) begin
            random_pick = (follow.size() == 0);
            if (!random_pick) begin
                stim_write[k] = 1'b0;
                stim_line[k] = follow.pop_front();
            end else begin
                stim_write[k] = (({$random(seed)} % 10) < 3);
                stim_line[k] = pool_line(int'({$random(seed)} % num_lines));
            end
            for (int w = 0; w < line_w / 32; w++) begin
                stim_data[k][w*32 +: 32] = $random(seed);
            end
            model_access(stim_write[k], stim_line[k], src, disp, disp_ok);
            if (stim_write[k]) begin
                ref_mem[stim_line[k]] = stim_data[k];
                exp_wr_line.push_back(stim_line[k]);
                exp_wr_data.push_back(stim_data[k]);
                n_writes++;
                // read the new data straight back now and then
                if ({$random(seed)} % 2 == 0) begin
                    follow.push_back(stim_line[k]);
                end
            end else begin
                exp_rsp_data.push_back(ref_read(stim_line[k]));
                exp_rsp_src.push_back(src);
                n_reads++;
                if (src == cache_link_pkg::src_victim) begin
                    n_victim++;
                end
                // after a swap, re-read both the swapped line and the one it pushed out
                if (random_pick && src == cache_link_pkg::src_victim) begin
                    follow.push_back(stim_line[k]);
                    if (disp_ok) begin
                        follow.push_back(disp);
                    end
                end
            end
        end
    endtask

    task automatic compare_line(input logic [line_w-1:0] got, input logic [line_w-1:0] exp,
                                input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_line_addr(input logic [laddr_w-1:0] got,
                                     input logic [laddr_w-1:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_src(input cache_link_pkg::rsp_src_e got,
                               input cache_link_pkg::rsp_src_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: rsp_src got %s expected %s", $time,
                     got.name(), exp.name());
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_quiet();
        compare_flag(rsp_valid, 1'b0, "rsp_valid");
        compare_flag(mem_req_valid, 1'b0, "mem_req_valid");
        compare_flag(req_credit, 1'b0, "req_credit");
    endtask

    // client side monitor
    always @(posedge clk) begin
        if (rstn) begin
            if (req_credit) begin
                credits_held++;
                credits_back++;
            end
            if (rsp_valid) begin
                if (exp_rsp_src.size() == 0) begin
                    errors++;
                    $display("Read response at %0t with no read outstanding", $time);
                end else begin
                    compare_line(rsp_data, exp_rsp_data.pop_front(), "read data");
                    compare_src(rsp_src, exp_rsp_src.pop_front());
                end
            end
        end
    end

    // memory responder takes requests at the edge and drives answers just after
    always @(posedge clk) begin
        if (rstn && mem_req_valid) begin
            if (mem_req_write) begin
                mem_writes++;
                mem_store[mem_req_line] = mem_req_data;
                if (exp_wr_line.size() == 0) begin
                    errors++;
                    $display("Memory write at %0t with no client write pending", $time);
                end else begin
                    compare_line_addr(mem_req_line, exp_wr_line.pop_front(), "write line");
                    compare_line(mem_req_data, exp_wr_data.pop_front(), "write data");
                end
            end else begin
                rd_line_q.push_back(mem_req_line);
                rd_due_q.push_back(cycle + int'({$random(seed)} % 4));
            end
            credit_due_q.push_back(cycle + int'({$random(seed)} % 3));
        end
        #1;
        mem_credit = 1'b0;
        mem_rsp_valid = 1'b0;
        if (credit_due_q.size() > 0 && credit_due_q[0] <= cycle) begin
            mem_credit = 1'b1;
            void'(credit_due_q.pop_front());
        end
        if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
            mem_rsp_valid = 1'b1;
            void'(rd_due_q.pop_front());
            if (mem_store.exists(rd_line_q[0])) begin
                mem_rsp_data = mem_store[rd_line_q[0]];
            end else begin
                mem_rsp_data = init_pattern(rd_line_q[0]);
            end
            void'(rd_line_q.pop_front());
        end
    end

    always @(negedge clk) begin
        cycle++;
        if (cycle >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        int k;
        int base;
        clk = 1'b0;
        rstn = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr = '0;
        req_data = '0;
        mem_credit = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        credits_held = cache_link_pkg::client_credits;
        build_stimulus();

        // outputs must already be low during reset and stay low after it
        repeat (2) @(posedge clk);
        repeat (6) begin
            @(posedge clk);
            check_quiet();
        end
        #1 rstn = 1'b1;
        repeat (3) begin
            @(posedge clk);
            check_quiet();
        end
        $display("test reset_quiet finished, errors %0d", errors);

        base = errors;
        k = 0;
        while (k < num_reqs) begin
            @(posedge clk);
            #1;
            if (credits_held > 0) begin
                req_valid = 1'b1;
                req_write = stim_write[k];
                req_addr.la.line = stim_line[k];
                req_addr.la.offset = 6'(k);
                req_data = stim_data[k];
                credits_held--;
                k++;
            end else begin
                req_valid = 1'b0;
            end
        end
        @(posedge clk);
        #1 req_valid = 1'b0;
        while (exp_rsp_src.size() != 0 || exp_wr_line.size() != 0) begin
            @(posedge clk);
        end
        repeat (6) @(posedge clk);
        $display("test random_traffic finished: %0d reads, %0d writes, %0d victim hits, errors %0d",
                 n_reads, n_writes, n_victim, errors - base);

        base = errors;
        compare_count(credits_back, num_reqs, "req_credit pulses");
        compare_count(mem_writes, n_writes, "memory writes");
        $display("test credit_return finished, errors %0d", errors - base);

        $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycle);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: all.f
hdl/cache_geom_pkg.sv
hdl/cache_link_pkg.sv
hdl/line_store.sv
hdl/victim_buffer.sv
hdl/cache_ctrl.sv
hdl/dcache_top.sv
dv/dcache_asserts.sv
dv/dcache_tb.sv

// File: Makefile
SIM        = verilator
LINT_FLAGS = --lint-only --timing --timescale 1ns/100ps
SIM_FLAGS  = --binary --timing --assert --timescale 1ns/100ps
TOP        = dcache_tb
FILELIST   = all.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = Errors found
PASS_MSG   = No errors

.PHONY: lint sim clean

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	-./$(OBJ_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
